// File: Bender.yml
package:
  name: pe_mac

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/pe_pkg.sv
      - logic/pe_operand_if.sv
      - logic/pe_operand_regs.sv
      - logic/pe_lane_mul.sv
      - logic/pe_accumulator.sv
      - logic/pe_mac_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/pe_mac_tb.sv

// File: logic/pe_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

`include "pe_config.svh"

module pe_accumulator (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    // accumulator control
    input  wire                 i_mac_clear,
    input  wire                 i_mac_en,
    // registered products from the lanes
    input  pe_pkg::pe_acc_vec_t i_products,
    input  wire                 i_products_vld,
    // running sums
    output pe_pkg::pe_acc_vec_t o_acc
);

    // signed limits of one accumulator
    localparam pe_pkg::pe_acc_t acc_max = {1'b0, {(`PE_ACC_WIDTH-1){1'b1}}};
    localparam pe_pkg::pe_acc_t acc_min = {1'b1, {(`PE_ACC_WIDTH-1){1'b0}}};
    localparam int msb = `PE_ACC_WIDTH - 1;

    pe_pkg::pe_acc_vec_t acc_q;
    pe_pkg::pe_acc_vec_t acc_d;
    // wrapped sums and their overflow flags
    pe_pkg::pe_acc_vec_t sum;
    logic [`PE_LANES-1:0] ovf;
    logic clear_all;

    // disabled MAC behaves like a held clear
    assign clear_all = i_mac_clear | ~i_mac_en;

    //////////////////////////////
    // saturating add
    //////////////////////////////

    always_comb begin
        for (int l = 0; l < `PE_LANES; l++) begin
            sum[l] = acc_q[l] + i_products[l];
            // same input signs, different result sign
            ovf[l] = (acc_q[l][msb] == i_products[l][msb]) &&
                     (sum[l][msb] != acc_q[l][msb]);
            if (ovf[l]) begin
                // came out negative, so it ran past the top
                acc_d[l] = sum[l][msb] ? acc_max : acc_min;
            end else begin
                acc_d[l] = sum[l];
            end
        end
    end

    //////////////////////////////
    // accumulator register
    //////////////////////////////

    // clear wins over a product arriving on the same edge
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q <= '0;
        end else if (clear_all) begin
            acc_q <= '0;
        end else if (i_products_vld) begin
            acc_q <= acc_d;
        end
    end

    assign o_acc = acc_q;

    // a clear edge leaves every lane at zero for the next cycle
    a_clear_zeroes: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_mac_clear || !i_mac_en) |=> (o_acc == '0)
    ) else $error("accumulators not zero after clear or disable");

endmodule

`default_nettype wire

// File: logic/pe_config.svh
`ifndef PE_CONFIG_SVH
`define PE_CONFIG_SVH

// lane count of one processing element
`define PE_LANES 8

// signed weight and activation width
`define PE_DATA_WIDTH 8

// lane index width, wide enough to address every lane
`define PE_INDEX_WIDTH 3

// full product width, also the accumulator width
`define PE_ACC_WIDTH (2 * `PE_DATA_WIDTH)

`endif

// File: logic/pe_lane_mul.sv
`timescale 1ns/10ps
`default_nettype none

`include "pe_config.svh"

module pe_lane_mul (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    // held operands
    pe_operand_if.dst           i_ops,
    // registered products, one per lane
    output pe_pkg::pe_acc_vec_t o_products,
    output logic                o_products_vld
);

    // field view of the held weight word
    pe_pkg::pe_weight_fields_t fields;
    // activation chosen by each lane
    pe_pkg::pe_act_vec_t pick;
    // raw products before the register
    pe_pkg::pe_acc_vec_t prod_d;
    pe_pkg::pe_acc_vec_t prod_q;
    logic prod_vld_q;

    assign fields = i_ops.weight.fields;

    //////////////////////////////
    // select and multiply
    //////////////////////////////

    // index counts from the top lane downward
    // index 0 -> top lane, index max -> lane 0
    always_comb begin
        for (int l = 0; l < `PE_LANES; l++) begin
            pick[l]   = i_ops.act[`PE_LANES - 1 - fields.indices[l]];
            // both signed, so full 16-bit signed product
            prod_d[l] = fields.weights[l] * pick[l];
        end
    end

    //////////////////////////////
    // product register
    //////////////////////////////

    // loads only on a weight strobe
    // accumulator ignores it otherwise
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            prod_q     <= '0;
            prod_vld_q <= 1'b0;
        end else begin
            prod_vld_q <= i_ops.weight_vld;
            if (i_ops.weight_vld) begin
                prod_q <= prod_d;
            end
        end
    end

    assign o_products     = prod_q;
    assign o_products_vld = prod_vld_q;

    // product strobe must trace back to a weight strobe
    a_prod_after_weight: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_products_vld |-> $past(i_ops.weight_vld)
    ) else $error("product valid without a weight valid one cycle earlier");

endmodule

`default_nettype wire

// File: logic/pe_mac_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "pe_config.svh"

module pe_mac_top (
    input  wire                  i_clk,
    input  wire                  i_rst_n,
    // weight beat in
    input  pe_pkg::pe_weight_u   i_wdata,
    input  wire                  i_wdata_vld,
    // activation beat in
    input  pe_pkg::pe_act_vec_t  i_mdata,
    input  wire                  i_mdata_vld,
    // accumulator control
    input  wire                  i_mac_clear,
    input  wire                  i_mac_en,
    // forwarded to the next element
    output pe_pkg::pe_weight_u   o_wdata,
    output logic                 o_wdata_vld,
    output pe_pkg::pe_act_vec_t  o_mdata,
    output logic                 o_mdata_vld,
    // per-lane running sums
    output pe_pkg::pe_acc_vec_t  o_mac_result
);

    // operand stage to multiply stage
    pe_operand_if ops ();

    // multiply stage to accumulate stage
    pe_pkg::pe_acc_vec_t products;
    logic products_vld;

    //////////////////////////////
    // pipeline stages
    //////////////////////////////

    // stage 1, operand registers
    pe_operand_regs u_operand_regs (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wdata     (i_wdata),
        .i_wdata_vld (i_wdata_vld),
        .i_mdata     (i_mdata),
        .i_mdata_vld (i_mdata_vld),
        .o_ops       (ops)
    );

    // stage 2, lane select and product register
    pe_lane_mul u_lane_mul (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_ops          (ops),
        .o_products     (products),
        .o_products_vld (products_vld)
    );

    // stage 3, saturating accumulators
    pe_accumulator u_accumulator (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mac_clear    (i_mac_clear),
        .i_mac_en       (i_mac_en),
        .i_products     (products),
        .i_products_vld (products_vld),
        .o_acc          (o_mac_result)
    );

    //////////////////////////////
    // forwarding
    //////////////////////////////

    // held operands go straight on to the next element
    assign o_wdata     = ops.weight;
    assign o_wdata_vld = ops.weight_vld;
    assign o_mdata     = ops.act;
    assign o_mdata_vld = ops.act_vld;

endmodule

`default_nettype wire

// File: logic/pe_operand_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "pe_config.svh"

// registered operands, input side to lane multipliers
interface pe_operand_if;

    // held weight word and its delayed strobe
    pe_pkg::pe_weight_u weight;
    logic weight_vld;

    // held activation vector and its delayed strobe
    pe_pkg::pe_act_vec_t act;
    logic act_vld;

    // operand register side
    modport src (
        output weight, weight_vld,
        output act, act_vld
    );

    // multiplier side
    modport dst (
        input weight, weight_vld,
        input act, act_vld
    );

endinterface

`default_nettype wire

// File: logic/pe_operand_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "pe_config.svh"

module pe_operand_regs (
    input  wire                 i_clk,
    input  wire                 i_rst_n,
    // weight beat from the previous element
    input  pe_pkg::pe_weight_u  i_wdata,
    input  wire                 i_wdata_vld,
    // activation beat from the previous element
    input  pe_pkg::pe_act_vec_t i_mdata,
    input  wire                 i_mdata_vld,
    // held operands, also the forwarding path
    pe_operand_if.src           o_ops
);

    //////////////////////////////
    // weight side
    //////////////////////////////

    // word held until the next strobe
    // strobe copied one cycle late
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ops.weight     <= '0;
            o_ops.weight_vld <= 1'b0;
        end else begin
            o_ops.weight_vld <= i_wdata_vld;
            if (i_wdata_vld) begin
                o_ops.weight <= i_wdata;
            end
        end
    end

    //////////////////////////////
    // activation side
    //////////////////////////////

    // same scheme as weights
    // independent strobe, so an activation may land alone
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ops.act     <= '0;
            o_ops.act_vld <= 1'b0;
        end else begin
            o_ops.act_vld <= i_mdata_vld;
            if (i_mdata_vld) begin
                o_ops.act <= i_mdata;
            end
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // unknown weight bits would poison every lane downstream
    // and the next element in the array as well
    a_wdata_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_wdata_vld |-> !$isunknown(i_wdata.bits)
    ) else $error("weight strobe with unknown weight bits");

endmodule

`default_nettype wire

// File: logic/pe_pkg.sv
`default_nettype none

`include "pe_config.svh"

package pe_pkg;

    //////////////////////////////
    // scalar types
    //////////////////////////////

    // one weight or one activation
    typedef logic signed [`PE_DATA_WIDTH-1:0] pe_data_t;
    // picks an activation lane
    typedef logic [`PE_INDEX_WIDTH-1:0] pe_index_t;
    // product or running sum
    typedef logic signed [`PE_ACC_WIDTH-1:0] pe_acc_t;

    //////////////////////////////
    // vector types
    //////////////////////////////

    // lane 0 in the low bits
    typedef pe_data_t [`PE_LANES-1:0] pe_act_vec_t;

    // one accumulator per lane
    typedef pe_acc_t [`PE_LANES-1:0]
        pe_acc_vec_t;

    // weights on top, indices below
    typedef struct packed {
        pe_data_t [`PE_LANES-1:0] weights;
        pe_index_t [`PE_LANES-1:0] indices;
    } pe_weight_fields_t;

    // raw view for forwarding, field view for the lanes
    typedef union packed {
        logic [$bits(pe_weight_fields_t)-1:0] bits;
        pe_weight_fields_t fields;
    } pe_weight_u;

endpackage

`default_nettype wire

// File: project.f
+incdir+logic
logic/pe_pkg.sv
logic/pe_operand_if.sv
logic/pe_operand_regs.sv
logic/pe_lane_mul.sv
logic/pe_accumulator.sv
logic/pe_mac_top.sv
tests/pe_mac_tb.sv

// File: tests/pe_mac_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "pe_config.svh"

module pe_mac_tb;

    //////////////////////////////
    // run constants
    //////////////////////////////

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SEED           = 13259;
    // operand, product and accumulator stages
    localparam int PIPE_DEPTH     = 3;
    // signed accumulator limits
    localparam int ACC_MAX        = (1 << (`PE_ACC_WIDTH - 1)) - 1;
    localparam int ACC_MIN        = -(1 << (`PE_ACC_WIDTH - 1));

    // DUT inputs
    logic                i_clk;
    logic                i_rst_n;
    pe_pkg::pe_weight_u  i_wdata;
    logic                i_wdata_vld;
    pe_pkg::pe_act_vec_t i_mdata;
    logic                i_mdata_vld;
    logic                i_mac_clear;
    logic                i_mac_en;

    // DUT outputs
    pe_pkg::pe_weight_u  o_wdata;
    logic                o_wdata_vld;
    pe_pkg::pe_act_vec_t o_mdata;
    logic                o_mdata_vld;
    pe_pkg::pe_acc_vec_t o_mac_result;

    // reference accumulators, one per lane
    int model_acc [`PE_LANES];
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    pe_mac_top i_pe_mac_top (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wdata      (i_wdata),
        .i_wdata_vld  (i_wdata_vld),
        .i_mdata      (i_mdata),
        .i_mdata_vld  (i_mdata_vld),
        .i_mac_clear  (i_mac_clear),
        .i_mac_en     (i_mac_en),
        .o_wdata      (o_wdata),
        .o_wdata_vld  (o_wdata_vld),
        .o_mdata      (o_mdata),
        .o_mdata_vld  (o_mdata_vld),
        .o_mac_result (o_mac_result)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // run limit
    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // wide signed compare, covers words and lane sums
    task automatic check_value(input logic signed [127:0] actual,
                               input logic signed [127:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s, got %0d, expected %0d",
                     $time, msg, actual, expected);
        end
    endtask

    function automatic pe_pkg::pe_weight_u random_weight();
        pe_pkg::pe_weight_u w;
        for (int l = 0; l < `PE_LANES; l++) begin
            w.fields.weights[l] = pe_pkg::pe_data_t'($urandom);
            w.fields.indices[l] = pe_pkg::pe_index_t'($urandom);
        end
        return w;
    endfunction

    function automatic pe_pkg::pe_act_vec_t random_act();
        pe_pkg::pe_act_vec_t a;
        for (int l = 0; l < `PE_LANES; l++) begin
            a[l] = pe_pkg::pe_data_t'($urandom);
        end
        return a;
    endfunction

    // select from the top lane down, multiply, clamp the true sum
    task automatic model_add_beat(input pe_pkg::pe_weight_u w, input pe_pkg::pe_act_vec_t a);
        int sel;
        int prod;
        int sum;
        for (int l = 0; l < `PE_LANES; l++) begin
            sel  = `PE_LANES - 1 - int'(w.fields.indices[l]);
            prod = int'($signed(w.fields.weights[l])) * int'($signed(a[sel]));
            sum  = model_acc[l] + prod;
            if (sum > ACC_MAX) begin
                sum = ACC_MAX;
            end else if (sum < ACC_MIN) begin
                sum = ACC_MIN;
            end
            model_acc[l] = sum;
        end
    endtask

    // weight and activation together
    task automatic drive_beat(input pe_pkg::pe_weight_u w, input pe_pkg::pe_act_vec_t a);
        @(negedge i_clk);
        i_wdata     = w;
        i_mdata     = a;
        i_wdata_vld = 1'b1;
        i_mdata_vld = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge i_clk);
            i_wdata_vld = 1'b0;
            i_mdata_vld = 1'b0;
        end
    endtask

    // one clear edge, pipeline assumed empty
    task automatic clear_accumulators();
        @(negedge i_clk);
        i_wdata_vld = 1'b0;
        i_mdata_vld = 1'b0;
        i_mac_clear = 1'b1;
        @(negedge i_clk);
        i_mac_clear = 1'b0;
        for (int l = 0; l < `PE_LANES; l++) begin
            model_acc[l] = 0;
        end
    endtask

    task automatic check_lanes_model(input string tag);
        for (int l = 0; l < `PE_LANES; l++) begin
            check_value($signed(o_mac_result[l]), model_acc[l],
                        $sformatf("%s lane %0d", tag, l));
        end
    endtask

    task automatic check_lanes_const(input int value, input string tag);
        for (int l = 0; l < `PE_LANES; l++) begin
            check_value($signed(o_mac_result[l]), value, $sformatf("%s lane %0d", tag, l));
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_reset_state();
        check_value(o_wdata_vld, 1'b0, "reset wdata valid");
        check_value(o_mdata_vld, 1'b0, "reset mdata valid");
        check_value(o_wdata.bits, 0, "reset forwarded weight word");
        check_value(o_mdata, 0, "reset forwarded activations");
        check_lanes_const(0, "reset accumulator");
    endtask

    task automatic test_forwarding();
        pe_pkg::pe_weight_u w0;
        pe_pkg::pe_weight_u w1;
        pe_pkg::pe_act_vec_t a0;
        pe_pkg::pe_act_vec_t a1;
        w0 = random_weight();
        w1 = random_weight();
        a0 = random_act();
        a1 = random_act();
        // MAC off so the beats leave the sums alone
        i_mac_en = 1'b0;
        drive_beat(w0, a0);
        // new words with valids low must not load
        @(negedge i_clk);
        check_value(o_wdata_vld, 1'b1, "fwd wdata valid after beat");
        check_value(o_wdata.bits, w0.bits, "fwd weight word after beat");
        check_value(o_mdata_vld, 1'b1, "fwd mdata valid after beat");
        check_value(o_mdata, a0, "fwd activations after beat");
        i_wdata     = w1;
        i_mdata     = a1;
        i_wdata_vld = 1'b0;
        i_mdata_vld = 1'b0;
        @(negedge i_clk);
        check_value(o_wdata_vld, 1'b0, "fwd wdata valid while idle");
        check_value(o_wdata.bits, w0.bits, "fwd weight word held");
        check_value(o_mdata_vld, 1'b0, "fwd mdata valid while idle");
        check_value(o_mdata, a0, "fwd activations held");
        // weight strobe alone
        i_wdata_vld = 1'b1;
        @(negedge i_clk);
        check_value(o_wdata_vld, 1'b1, "fwd wdata valid, weight only");
        check_value(o_wdata.bits, w1.bits, "fwd weight word, weight only");
        check_value(o_mdata_vld, 1'b0, "fwd mdata valid, weight only");
        check_value(o_mdata, a0, "fwd activations, weight only");
        // activation strobe alone
        i_wdata_vld = 1'b0;
        i_mdata_vld = 1'b1;
        @(negedge i_clk);
        check_value(o_wdata_vld, 1'b0, "fwd wdata valid, act only");
        check_value(o_wdata.bits, w1.bits, "fwd weight word, act only");
        check_value(o_mdata_vld, 1'b1, "fwd mdata valid, act only");
        check_value(o_mdata, a1, "fwd activations, act only");
        idle_cycles(PIPE_DEPTH);
        i_mac_en = 1'b1;
        check_lanes_const(0, "fwd accumulator with MAC off");
    endtask

    task automatic test_index_select();
        int wv [`PE_LANES];
        int av [`PE_LANES];
        int idx [`PE_LANES];
        pe_pkg::pe_weight_u w;
        pe_pkg::pe_act_vec_t a;
        clear_accumulators();
        // permutation holding both 0 and the top index
        for (int l = 0; l < `PE_LANES; l++) begin
            wv[l]  = l * 11 - 40;
            av[l]  = l * 17 - 60;
            idx[l] = (l * 3) % `PE_LANES;
            w.fields.weights[l] = pe_pkg::pe_data_t'(wv[l]);
            w.fields.indices[l] = pe_pkg::pe_index_t'(idx[l]);
            a[l] = pe_pkg::pe_data_t'(av[l]);
        end
        // activation first, weight one cycle later
        @(negedge i_clk);
        i_mdata     = a;
        i_mdata_vld = 1'b1;
        @(negedge i_clk);
        i_mdata_vld = 1'b0;
        i_wdata     = w;
        i_wdata_vld = 1'b1;
        idle_cycles(2);
        check_lanes_const(0, "index select, one edge early");
        @(negedge i_clk);
        for (int l = 0; l < `PE_LANES; l++) begin
            check_value($signed(o_mac_result[l]), wv[l] * av[`PE_LANES - 1 - idx[l]],
                        $sformatf("index select lane %0d", l));
        end
    endtask

    task automatic test_accumulation();
        pe_pkg::pe_weight_u w;
        pe_pkg::pe_act_vec_t a;
        clear_accumulators();
        repeat (20) begin
            w = random_weight();
            a = random_act();
            drive_beat(w, a);
            model_add_beat(w, a);
        end
        idle_cycles(PIPE_DEPTH);
        check_lanes_model("random accumulate");
    endtask

    task automatic test_saturation();
        pe_pkg::pe_weight_u w;
        pe_pkg::pe_act_vec_t a;
        clear_accumulators();
        w = random_weight();
        for (int l = 0; l < `PE_LANES; l++) begin
            w.fields.weights[l] = 8'sd127;
            a[l] = 8'sd127;
        end
        // three products already pass the top
        repeat (4) drive_beat(w, a);
        idle_cycles(PIPE_DEPTH);
        check_lanes_const(ACC_MAX, "positive clamp");
        repeat (2) drive_beat(w, a);
        idle_cycles(PIPE_DEPTH);
        check_lanes_const(ACC_MAX, "positive clamp held");
        clear_accumulators();
        for (int l = 0; l < `PE_LANES; l++) begin
            w.fields.weights[l] = -8'sd128;
        end
        repeat (4) drive_beat(w, a);
        idle_cycles(PIPE_DEPTH);
        check_lanes_const(ACC_MIN, "negative clamp");
        repeat (2) drive_beat(w, a);
        idle_cycles(PIPE_DEPTH);
        check_lanes_const(ACC_MIN, "negative clamp held");
    endtask

    task automatic test_clear_enable();
        pe_pkg::pe_weight_u w;
        pe_pkg::pe_act_vec_t a;
        clear_accumulators();
        repeat (5) begin
            w = random_weight();
            a = random_act();
            drive_beat(w, a);
            model_add_beat(w, a);
        end
        idle_cycles(PIPE_DEPTH);
        check_lanes_model("sums before clear");
        clear_accumulators();
        check_lanes_const(0, "after clear pulse");
        // beats with MAC off never reach the sums
        i_mac_en = 1'b0;
        repeat (5) begin
            drive_beat(random_weight(), random_act());
            check_lanes_const(0, "beat with MAC off");
        end
        idle_cycles(PIPE_DEPTH);
        i_mac_en = 1'b1;
        idle_cycles(PIPE_DEPTH);
        check_lanes_const(0, "after MAC off beats");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        void'($urandom(SEED));
        i_rst_n     = 1'b0;
        i_wdata     = '0;
        i_wdata_vld = 1'b0;
        i_mdata     = '0;
        i_mdata_vld = 1'b0;
        i_mac_clear = 1'b0;
        i_mac_en    = 1'b1;
        for (int l = 0; l < `PE_LANES; l++) begin
            model_acc[l] = 0;
        end
        // count rising edges in reset, release between edges
        repeat (RESET_CYCLES) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;

        test_reset_state();
        test_forwarding();
        test_index_select();
        test_accumulation();
        test_saturation();
        test_clear_enable();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
